// File: Bender.yml
package:
  name: mem_tile

sources:
  - files:
      - hw/tile_pkg.sv
      - hw/addr_demux.sv
      - hw/l1_interco.sv
      - hw/l1_spm.sv
      - hw/dma_engine.sv
      - hw/l2_mux.sv
      - hw/mem_tile.sv
  - target: test
    files:
      - dv/tb_mem_tile.sv

// File: all.f
hw/tile_pkg.sv
hw/addr_demux.sv
hw/l1_interco.sv
hw/l1_spm.sv
hw/dma_engine.sv
hw/l2_mux.sv
hw/mem_tile.sv
dv/tb_mem_tile.sv

// File: dv/tb_mem_tile.sv
`timescale 1ns/1ns

module tb_mem_tile;

  localparam string CASE_FILE = "dv/tile_cases.txt";
  localparam int unsigned TIMEOUT  = 100;  // Cycles per handshake wait
  localparam int unsigned POLL_MAX = 200;  // Status reads before giving up
  localparam logic [31:0] ERR_LO = 32'h3000_0000;  // L2 window that answers err
  localparam logic [31:0] ERR_HI = 32'h3000_00FF;

  logic clk_i = 1'b0;
  logic rst_ni;
  tile_pkg::mem_req_t host_req, l2_req;
  tile_pkg::mem_rsp_t host_rsp, l2_rsp, l2_rsp_q;
  tile_pkg::irq_t irq_in, irq_out;
  logic gnt_en;  // L2 model ready to grant this cycle
  logic [31:0] lfsr_q = 32'haf16_5736;
  logic [31:0] l2_mem [logic [29:0]];  // Sparse L2 indexed by word address
  int unsigned n_val_err = 0;
  int unsigned n_other_err = 0;

  always #4 clk_i = ~clk_i;

  mem_tile #(
    .N_BANKS(tile_pkg::N_BANKS_DEF),
    .N_WORDS(tile_pkg::N_WORDS_DEF)
  ) mem_tile_i (
    .clk_i, .rst_ni,
    .host_req_i (host_req), .host_rsp_o (host_rsp),
    .l2_req_o   (l2_req),   .l2_rsp_i   (l2_rsp),
    .irq_i      (irq_in),   .irq_o      (irq_out)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int unsigned rand_bits(input int unsigned nbits);
    int unsigned v;
    v = 0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = (v << 1) | lfsr_q[0];
    end
    return v;
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    if (l2_mem.exists(addr[31:2])) return l2_mem[addr[31:2]];
    return '0;
  endfunction

  task automatic check_data(input string name, input logic [tile_pkg::DATA_W-1:0] exp,
                            input logic [tile_pkg::DATA_W-1:0] act);
    if (act !== exp) begin
      $display("ERR %s: expected %h, got %h", name, exp, act);
      n_val_err++;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s: expected %h, got %h", name, exp, act);
      n_val_err++;
    end
  endtask

  task automatic check_irq(input string name, input tile_pkg::irq_t exp,
                           input tile_pkg::irq_t act);
    if (act !== exp) begin
      $display("ERR %s: expected %h, got %h", name, exp, act);
      n_val_err++;
    end
  endtask

  // L2 memory model with random grant and response delays
  always_comb begin
    l2_rsp     = l2_rsp_q;
    l2_rsp.gnt = gnt_en && l2_req.req;
  end

  initial begin : l2_model
    tile_pkg::mem_req_t acc;
    int unsigned gnt_wait, rsp_wait;
    logic busy;
    logic [31:0] word;
    logic bad;
    l2_rsp_q = '0;
    gnt_en   = 1'b0;
    busy     = 1'b0;
    rsp_wait = 0;
    word     = '0;
    bad      = 1'b0;
    gnt_wait = rand_bits(2);
    forever begin
      @(negedge clk_i);
      l2_rsp_q = '0;
      if (busy) begin
        gnt_en = 1'b0;
        if (rsp_wait == 0) begin
          l2_rsp_q.rvalid = 1'b1;
          l2_rsp_q.rdata  = word;
          l2_rsp_q.err    = bad;
          busy     = 1'b0;
          gnt_wait = rand_bits(2);
        end else begin
          rsp_wait--;
        end
      end else begin
        gnt_en = (gnt_wait == 0);
      end
      #2;  // Inputs and DUT outputs have settled by now
      if (!busy && l2_req.req) begin
        if (gnt_en) begin
          acc      = l2_req;
          busy     = 1'b1;
          rsp_wait = rand_bits(2);
          bad      = acc.addr >= ERR_LO && acc.addr <= ERR_HI;
          word     = model_word(acc.addr);
          if (acc.we && !bad) begin
            for (int b = 0; b < 4; b++) begin
              if (acc.be[b]) word[8*b +: 8] = acc.wdata[8*b +: 8];
            end
            l2_mem[acc.addr[31:2]] = word;
          end
          if (acc.we || bad) word = '0;
        end else if (gnt_wait != 0) begin
          gnt_wait--;
        end
      end
    end
  end

  task automatic host_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be,
                             output logic [31:0] rdata, output logic err);
    int unsigned n;
    logic granted;
    rdata = '0;
    err   = 1'b0;
    @(negedge clk_i);
    host_req = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    n = 0;
    #2;
    while (!host_rsp.gnt && n < TIMEOUT) begin
      @(negedge clk_i);
      #2;
      n++;
    end
    granted = host_rsp.gnt;
    @(negedge clk_i);
    host_req = '0;
    if (!granted) begin
      $display("Host access to %h was never granted", addr);
      n_other_err++;
      return;
    end
    n = 0;
    #2;
    while (!host_rsp.rvalid && n < TIMEOUT) begin
      @(negedge clk_i);
      #2;
      n++;
    end
    if (!host_rsp.rvalid) begin
      $display("Host access to %h got no response", addr);
      n_other_err++;
      return;
    end
    rdata = host_rsp.rdata;
    err   = host_rsp.err;
  endtask

  task automatic poll_done(input logic [31:0] addr, output logic [31:0] status);
    int unsigned n;
    logic e;
    status = '0;
    n = 0;
    do begin
      host_access(1'b0, addr, '0, '1, status, e);
      check_err("host_rsp_o.err", 1'b0, e);
      n++;
    end while (!status[1] && n < POLL_MAX);  // Bit 1 is done
    if (!status[1]) begin
      $display("DMA did not report done after %0d status reads", n);
      n_other_err++;
    end
  endtask

  initial begin : main_seq
    int fd, code;
    string line;
    logic [7:0] op;
    logic [31:0] addr, data, exp, rd;
    logic [3:0] be;
    logic er;
    host_req = '0;
    irq_in   = '0;
    rst_ni   = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the case file %s", CASE_FILE);
      n_other_err++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code == 0) break;
        if (line.len() < 9 || line.getc(0) == "#") continue;  // Blank or comment
        if ($sscanf(line, "%c %h %h %h %h", op, addr, data, be, exp) != 5) begin
          $display("Could not parse the case file line %s", line);
          n_other_err++;
          continue;
        end
        case (op)
          "W": begin
            host_access(1'b1, addr, data, be, rd, er);
            check_err("host_rsp_o.err", exp[0], er);
          end
          "R": begin
            host_access(1'b0, addr, '0, be, rd, er);
            check_data("host_rsp_o.rdata", data, rd);
            check_err("host_rsp_o.err", exp[0], er);
          end
          "M": check_data("l2_model_word", data, model_word(addr));
          "I": begin
            @(negedge clk_i);
            irq_in = data;
            #2;
            check_irq("irq_o", exp, irq_out);
          end
          "P": begin
            poll_done(addr, rd);
            check_data("dma_status", data, rd);
          end
          default: begin
            $display("Unknown operation %c in the case file", op);
            n_other_err++;
          end
        endcase
      end
      $fclose(fd);
    end
    $display("Errors: %0d wrong values, %0d other failures", n_val_err, n_other_err);
    if (n_val_err + n_other_err == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: dv/tile_cases.txt
# op addr data be exp, all hex
# R data = expected rdata, exp = expected err; I data = irq_i, exp = irq_o; P data = status
W 10000000 11111111 f 0
W 10000004 22222222 f 0
W 10000008 33333333 f 0
W 1000000c 44444444 f 0
W 10000004 aabbccdd 3 0
W 10000008 00ee0000 4 0
W 1000000c 55667788 c 0
R 10000000 11111111 f 0
R 10000004 2222ccdd f 0
R 10000008 33ee3333 f 0
R 1000000c 55664444 f 0
W 40000000 cafef00d f 0
W 40000004 12345678 6 0
M 40000000 cafef00d 0 0
M 40000004 00345600 0 0
R 40000000 cafef00d f 0
R 30000010 00000000 f 1
W 50000000 a5a5a5a5 f 0
W 50000004 0badc0de f 0
W 20000000 50000000 f 0
W 20000004 10000100 f 0
W 20000008 00000002 f 0
W 2000000c 00000001 f 0
P 2000000c 00000002 f 0
R 10000100 a5a5a5a5 f 0
R 10000104 0badc0de f 0
I 00000000 00000000 0 00040000
W 20000000 10000000 f 0
W 20000004 60000000 f 0
W 20000008 00000002 f 0
W 2000000c 00000003 f 0
P 2000000c 00000002 f 0
M 60000000 11111111 0 0
M 60000004 2222ccdd 0 0
W 2000000c 00000004 f 0
R 2000000c 00000000 f 0
I 00000000 00000000 0 00000000
W 20000000 30000000 f 0
W 20000004 10000200 f 0
W 20000008 00000002 f 0
W 2000000c 00000001 f 0
P 2000000c 00000006 f 0
I 00000000 00000000 0 000c0000
W 2000000c 00000004 f 0
I 00000000 ffffffff 0 00000888

// File: hw/addr_demux.sv
`timescale 1ns/1ns

module addr_demux #(
  parameter int unsigned N_BANKS = tile_pkg::N_BANKS_DEF,
  parameter int unsigned N_WORDS = tile_pkg::N_WORDS_DEF
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  tile_pkg::mem_req_t host_req_i,
  output tile_pkg::mem_rsp_t host_rsp_o,
  output tile_pkg::mem_req_t l1_req_o,
  input  tile_pkg::mem_rsp_t l1_rsp_i,
  output tile_pkg::mem_req_t l2_req_o,
  input  tile_pkg::mem_rsp_t l2_rsp_i,
  output tile_pkg::mem_req_t reg_req_o,
  input  tile_pkg::mem_rsp_t reg_rsp_i
);

  localparam logic [tile_pkg::ADDR_W-1:0] L1Size = N_BANKS * N_WORDS * 4;

  tile_pkg::target_e tgt_d, tgt_q, sel_tgt;
  tile_pkg::mem_rsp_t sel_rsp;
  logic pend_q;  // One host transaction in flight

  always_comb begin
    tgt_d = tile_pkg::TGT_L2;  // Anything unmapped goes out to L2
    if (host_req_i.addr >= tile_pkg::L1_BASE && host_req_i.addr < tile_pkg::L1_BASE + L1Size)
      tgt_d = tile_pkg::TGT_L1;
    else if (host_req_i.addr >= tile_pkg::DMA_BASE &&
             host_req_i.addr < tile_pkg::DMA_BASE + tile_pkg::DMA_SIZE)
      tgt_d = tile_pkg::TGT_DMA;
  end

  always_comb begin
    l1_req_o      = host_req_i;
    l2_req_o      = host_req_i;
    reg_req_o     = host_req_i;
    l1_req_o.req  = host_req_i.req && !pend_q && tgt_d == tile_pkg::TGT_L1;
    l2_req_o.req  = host_req_i.req && !pend_q && tgt_d == tile_pkg::TGT_L2;
    reg_req_o.req = host_req_i.req && !pend_q && tgt_d == tile_pkg::TGT_DMA;
  end

  // While pending, the recorded target owns the response path
  assign sel_tgt = pend_q ? tgt_q : tgt_d;

  always_comb begin
    unique case (sel_tgt)
      tile_pkg::TGT_L1:  sel_rsp = l1_rsp_i;
      tile_pkg::TGT_DMA: sel_rsp = reg_rsp_i;
      default:           sel_rsp = l2_rsp_i;
    endcase
    host_rsp_o        = sel_rsp;
    host_rsp_o.gnt    = sel_rsp.gnt && host_req_i.req && !pend_q;
    host_rsp_o.rvalid = sel_rsp.rvalid && pend_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
      tgt_q  <= tile_pkg::TGT_L2;
    end else if (host_rsp_o.gnt) begin
      pend_q <= 1'b1;
      tgt_q  <= tgt_d;
    end else if (host_rsp_o.rvalid) begin
      pend_q <= 1'b0;
    end
  end

endmodule

// File: hw/dma_engine.sv
`timescale 1ns/1ns

module dma_engine (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  tile_pkg::mem_req_t reg_req_i,
  output tile_pkg::mem_rsp_t reg_rsp_o,
  output tile_pkg::mem_req_t l1_req_o,
  input  tile_pkg::mem_rsp_t l1_rsp_i,
  output tile_pkg::mem_req_t l2_req_o,
  input  tile_pkg::mem_rsp_t l2_rsp_i,
  output logic               start_o,
  output logic               busy_o,
  output logic               done_o,
  output logic               error_o
);

  typedef enum logic [2:0] {ST_IDLE, ST_RD, ST_RD_WAIT, ST_WR, ST_WR_WAIT} state_e;

  state_e state_q;
  logic [tile_pkg::ADDR_W-1:0] src_q, dst_q;
  logic [tile_pkg::DATA_W-1:0] len_q, word_q, reg_rdata, reg_rdata_q;
  logic dir_q, busy_q, done_q, error_q, start_q, reg_rvalid_q;
  logic reg_wr, ctrl_wr, go;
  tile_pkg::mem_req_t rd_req, wr_req;
  tile_pkg::mem_rsp_t src_rsp, dst_rsp;

  assign reg_wr  = reg_req_i.req && reg_req_i.we;
  assign ctrl_wr = reg_wr && reg_req_i.addr[3:0] == tile_pkg::REG_CTRL;
  assign go      = ctrl_wr && reg_req_i.wdata[0] && !busy_q;  // Start while busy is dropped

  always_comb begin
    unique case (reg_req_i.addr[3:0])
      tile_pkg::REG_SRC: reg_rdata = src_q;
      tile_pkg::REG_DST: reg_rdata = dst_q;
      tile_pkg::REG_LEN: reg_rdata = len_q;
      default:           reg_rdata = {29'b0, error_q, done_q, busy_q};
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) reg_rvalid_q <= 1'b0;
    else         reg_rvalid_q <= reg_req_i.req;
  end

  always_ff @(posedge clk_i) begin
    reg_rdata_q <= reg_rdata;
    if (state_q == ST_RD_WAIT && src_rsp.rvalid) word_q <= src_rsp.rdata;
  end

  assign reg_rsp_o = '{gnt: reg_req_i.req, rvalid: reg_rvalid_q, rdata: reg_rdata_q, err: 1'b0};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      src_q   <= '0;
      dst_q   <= '0;
      len_q   <= '0;
      dir_q   <= 1'b0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      error_q <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= go;  // One cycle per accepted copy
      if (reg_wr && !busy_q) begin
        unique case (reg_req_i.addr[3:0])
          tile_pkg::REG_SRC: src_q <= reg_req_i.wdata;
          tile_pkg::REG_DST: dst_q <= reg_req_i.wdata;
          tile_pkg::REG_LEN: len_q <= reg_req_i.wdata;
          default: ;
        endcase
      end
      if (ctrl_wr && reg_req_i.wdata[2]) begin
        done_q  <= 1'b0;
        error_q <= 1'b0;
      end
      if (go) begin
        dir_q   <= reg_req_i.wdata[1];
        done_q  <= (len_q == '0);  // Empty copy finishes at once
        error_q <= 1'b0;
        if (len_q != '0) begin
          busy_q  <= 1'b1;
          state_q <= ST_RD;
        end
      end
      unique case (state_q)
        ST_RD: if (src_rsp.gnt) state_q <= ST_RD_WAIT;
        ST_RD_WAIT: begin
          if (src_rsp.rvalid) begin
            if (src_rsp.err) begin
              state_q <= ST_IDLE;
              busy_q  <= 1'b0;
              done_q  <= 1'b1;
              error_q <= 1'b1;
            end else begin
              state_q <= ST_WR;
            end
          end
        end
        ST_WR: if (dst_rsp.gnt) state_q <= ST_WR_WAIT;
        ST_WR_WAIT: begin
          if (dst_rsp.rvalid) begin
            src_q <= src_q + 4;
            dst_q <= dst_q + 4;
            len_q <= len_q - 1;
            if (dst_rsp.err || len_q == 1) begin
              state_q <= ST_IDLE;
              busy_q  <= 1'b0;
              done_q  <= 1'b1;
              error_q <= dst_rsp.err;
            end else begin
              state_q <= ST_RD;
            end
          end
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_req       = '0;
    rd_req.req   = state_q == ST_RD;
    rd_req.be    = '1;
    rd_req.addr  = src_q;
    wr_req       = '0;
    wr_req.req   = state_q == ST_WR;
    wr_req.we    = 1'b1;
    wr_req.be    = '1;
    wr_req.addr  = dst_q;
    wr_req.wdata = word_q;
  end

  // Direction 0 reads L2 and writes L1, direction 1 the reverse
  assign l2_req_o = dir_q ? wr_req : rd_req;
  assign l1_req_o = dir_q ? rd_req : wr_req;
  assign src_rsp  = dir_q ? l1_rsp_i : l2_rsp_i;
  assign dst_rsp  = dir_q ? l2_rsp_i : l1_rsp_i;

  assign start_o = start_q;
  assign busy_o  = busy_q;
  assign done_o  = done_q;
  assign error_o = error_q;

endmodule

// File: hw/l1_interco.sv
`timescale 1ns/1ns

module l1_interco #(
  parameter int unsigned N_BANKS = tile_pkg::N_BANKS_DEF,
  parameter int unsigned N_WORDS = tile_pkg::N_WORDS_DEF
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  tile_pkg::mem_req_t                      host_req_i,
  output tile_pkg::mem_rsp_t                      host_rsp_o,
  input  tile_pkg::mem_req_t                      dma_req_i,
  output tile_pkg::mem_rsp_t                      dma_rsp_o,
  output tile_pkg::bank_req_t [N_BANKS-1:0]       bank_req_o,
  input  logic [N_BANKS-1:0][tile_pkg::DATA_W-1:0] bank_rdata_i
);

  localparam int unsigned BankW = $clog2(N_BANKS);
  localparam int unsigned RowW  = $clog2(N_WORDS);

  logic [BankW-1:0] host_bank, dma_bank, host_bank_q, dma_bank_q;
  tile_pkg::bank_req_t host_breq, dma_breq;
  logic host_gnt, dma_gnt, host_rv_q, dma_rv_q;

  function automatic logic [BankW-1:0] bank_of(tile_pkg::mem_req_t r);
    logic [tile_pkg::ADDR_W-1:0] off;
    off = r.addr - tile_pkg::L1_BASE;
    return off[2 +: BankW];  // Word interleaved
  endfunction

  function automatic tile_pkg::bank_req_t to_bank(tile_pkg::mem_req_t r);
    tile_pkg::bank_req_t b;
    logic [tile_pkg::ADDR_W-1:0] off;
    off = r.addr - tile_pkg::L1_BASE;
    b = '0;
    b.req = r.req;
    b.we = r.we;
    b.be = r.be;
    b.wdata = r.wdata;
    b.row[RowW-1:0] = off[2+BankW +: RowW];  // Row from bits above the bank index
    return b;
  endfunction

  assign host_bank = bank_of(host_req_i);
  assign dma_bank  = bank_of(dma_req_i);
  assign host_breq = to_bank(host_req_i);
  assign dma_breq  = to_bank(dma_req_i);

  // Host always wins a shared bank
  assign host_gnt = host_req_i.req;
  assign dma_gnt  = dma_req_i.req && !(host_req_i.req && host_bank == dma_bank);

  always_comb begin
    for (int b = 0; b < N_BANKS; b++) begin
      bank_req_o[b] = '0;
      if (host_gnt && host_bank == BankW'(b))
        bank_req_o[b] = host_breq;
      else if (dma_gnt && dma_bank == BankW'(b))
        bank_req_o[b] = dma_breq;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      host_rv_q   <= 1'b0;
      dma_rv_q    <= 1'b0;
      host_bank_q <= '0;
      dma_bank_q  <= '0;
    end else begin
      host_rv_q   <= host_gnt;
      dma_rv_q    <= dma_gnt;
      host_bank_q <= host_bank;  // Selects rdata next cycle
      dma_bank_q  <= dma_bank;
    end
  end

  assign host_rsp_o = '{gnt: host_gnt, rvalid: host_rv_q,
                        rdata: bank_rdata_i[host_bank_q], err: 1'b0};
  assign dma_rsp_o  = '{gnt: dma_gnt, rvalid: dma_rv_q,
                        rdata: bank_rdata_i[dma_bank_q], err: 1'b0};

endmodule

// File: hw/l1_spm.sv
`timescale 1ns/1ns

module l1_spm #(
  parameter int unsigned N_BANKS = tile_pkg::N_BANKS_DEF,
  parameter int unsigned N_WORDS = tile_pkg::N_WORDS_DEF
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  tile_pkg::bank_req_t [N_BANKS-1:0]        bank_req_i,
  output logic [N_BANKS-1:0][tile_pkg::DATA_W-1:0] bank_rdata_o
);

  localparam int unsigned RowW = $clog2(N_WORDS);

  for (genvar b = 0; b < N_BANKS; b++) begin : gen_bank
    logic [tile_pkg::DATA_W-1:0] mem [N_WORDS];
    logic [RowW-1:0] row;

    assign row = bank_req_i[b].row[RowW-1:0];

    initial begin
      for (int i = 0; i < N_WORDS; i++) mem[i] = '0;  // Scratchpad powers up cleared
    end

    always_ff @(posedge clk_i) begin
      if (bank_req_i[b].req && bank_req_i[b].we) begin
        for (int i = 0; i < tile_pkg::BE_W; i++) begin
          if (bank_req_i[b].be[i]) mem[row][8*i +: 8] <= bank_req_i[b].wdata[8*i +: 8];
        end
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) bank_rdata_o[b] <= '0;
      else if (bank_req_i[b].req && !bank_req_i[b].we) bank_rdata_o[b] <= mem[row];
    end
  end

endmodule

// File: hw/l2_mux.sv
`timescale 1ns/1ns

module l2_mux (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  tile_pkg::mem_req_t host_req_i,
  output tile_pkg::mem_rsp_t host_rsp_o,
  input  tile_pkg::mem_req_t dma_req_i,
  output tile_pkg::mem_rsp_t dma_rsp_o,
  output tile_pkg::mem_req_t l2_req_o,
  input  tile_pkg::mem_rsp_t l2_rsp_i
);

  logic sel;      // 0 host, 1 DMA
  logic owner_q;
  logic lock_q;   // Held from grant to rvalid
  logic prio_q;   // Winner of the next conflict

  assign sel = dma_req_i.req && (!host_req_i.req || prio_q);

  always_comb begin
    l2_req_o     = sel ? dma_req_i : host_req_i;
    l2_req_o.req = !lock_q && (host_req_i.req || dma_req_i.req);
  end

  always_comb begin
    host_rsp_o = '0;
    dma_rsp_o  = '0;
    if (lock_q) begin
      if (owner_q) dma_rsp_o = l2_rsp_i;
      else         host_rsp_o = l2_rsp_i;
      host_rsp_o.gnt = 1'b0;
      dma_rsp_o.gnt  = 1'b0;
    end else begin
      host_rsp_o.gnt = l2_rsp_i.gnt && l2_req_o.req && !sel;
      dma_rsp_o.gnt  = l2_rsp_i.gnt && l2_req_o.req && sel;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q <= 1'b0;
      lock_q  <= 1'b0;
      prio_q  <= 1'b0;
    end else if (!lock_q) begin
      if (l2_req_o.req && l2_rsp_i.gnt) begin
        lock_q  <= 1'b1;
        owner_q <= sel;
        prio_q  <= !sel;  // Alternate when both wait
      end
    end else if (l2_rsp_i.rvalid) begin
      lock_q <= 1'b0;
    end
  end

endmodule

// File: hw/mem_tile.sv
`timescale 1ns/1ns

module mem_tile #(
  parameter int unsigned N_BANKS = tile_pkg::N_BANKS_DEF,
  parameter int unsigned N_WORDS = tile_pkg::N_WORDS_DEF
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  tile_pkg::mem_req_t host_req_i,
  output tile_pkg::mem_rsp_t host_rsp_o,
  output tile_pkg::mem_req_t l2_req_o,
  input  tile_pkg::mem_rsp_t l2_rsp_i,
  input  tile_pkg::irq_t     irq_i,
  output tile_pkg::irq_t     irq_o
);

  tile_pkg::mem_req_t host_l1_req, host_l2_req, host_reg_req, dma_l1_req, dma_l2_req;
  tile_pkg::mem_rsp_t host_l1_rsp, host_l2_rsp, host_reg_rsp, dma_l1_rsp, dma_l2_rsp;
  tile_pkg::bank_req_t [N_BANKS-1:0] bank_req;
  logic [N_BANKS-1:0][tile_pkg::DATA_W-1:0] bank_rdata;
  logic dma_start, dma_busy, dma_done, dma_error;

  addr_demux #(.N_BANKS(N_BANKS), .N_WORDS(N_WORDS)) i_addr_demux (
    .clk_i, .rst_ni, .host_req_i, .host_rsp_o,
    .l1_req_o  (host_l1_req),  .l1_rsp_i  (host_l1_rsp),
    .l2_req_o  (host_l2_req),  .l2_rsp_i  (host_l2_rsp),
    .reg_req_o (host_reg_req), .reg_rsp_i (host_reg_rsp)
  );

  l1_interco #(.N_BANKS(N_BANKS), .N_WORDS(N_WORDS)) i_l1_interco (
    .clk_i, .rst_ni,
    .host_req_i   (host_l1_req), .host_rsp_o (host_l1_rsp),
    .dma_req_i    (dma_l1_req),  .dma_rsp_o  (dma_l1_rsp),
    .bank_req_o   (bank_req),
    .bank_rdata_i (bank_rdata)
  );

  l1_spm #(.N_BANKS(N_BANKS), .N_WORDS(N_WORDS)) i_l1_spm (
    .clk_i, .rst_ni,
    .bank_req_i   (bank_req),
    .bank_rdata_o (bank_rdata)
  );

  dma_engine i_dma_engine (
    .clk_i, .rst_ni,
    .reg_req_i (host_reg_req), .reg_rsp_o (host_reg_rsp),
    .l1_req_o  (dma_l1_req),   .l1_rsp_i  (dma_l1_rsp),
    .l2_req_o  (dma_l2_req),   .l2_rsp_i  (dma_l2_rsp),
    .start_o   (dma_start),    .busy_o    (dma_busy),
    .done_o    (dma_done),     .error_o   (dma_error)
  );

  l2_mux i_l2_mux (
    .clk_i, .rst_ni,
    .host_req_i (host_l2_req), .host_rsp_o (host_l2_rsp),
    .dma_req_i  (dma_l2_req),  .dma_rsp_o  (dma_l2_rsp),
    .l2_req_o, .l2_rsp_i
  );

  always_comb begin
    irq_o = irq_i & tile_pkg::IRQ_EXT_MASK;  // External lines keep their positions
    irq_o[tile_pkg::IRQ_DMA_START] = dma_start;
    irq_o[tile_pkg::IRQ_DMA_BUSY]  = dma_busy;
    irq_o[tile_pkg::IRQ_DMA_DONE]  = dma_done;
    irq_o[tile_pkg::IRQ_DMA_ERROR] = dma_error;
  end

endmodule

// File: hw/tile_pkg.sv
package tile_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;
  localparam int unsigned ROW_W  = 16;  // Widest row index a bank may use

  localparam int unsigned N_BANKS_DEF = 4;
  localparam int unsigned N_WORDS_DEF = 64;

  // Address map
  localparam logic [ADDR_W-1:0] L1_BASE  = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] DMA_BASE = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] DMA_SIZE = 32'h0000_0010;

  // DMA register offsets inside its window
  localparam logic [3:0] REG_SRC  = 4'h0;  // Source byte address
  localparam logic [3:0] REG_DST  = 4'h4;  // Destination byte address
  localparam logic [3:0] REG_LEN  = 4'h8;  // Word count
  localparam logic [3:0] REG_CTRL = 4'hC;  // Start, direction, clear / status

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_L1,
    TGT_DMA
  } target_e;

  // Interrupt vector layout
  localparam int unsigned N_IRQ         = 32;
  localparam int unsigned IRQ_DMA_START = 16;
  localparam int unsigned IRQ_DMA_BUSY  = 17;
  localparam int unsigned IRQ_DMA_DONE  = 18;
  localparam int unsigned IRQ_DMA_ERROR = 19;
  localparam logic [N_IRQ-1:0] IRQ_EXT_MASK = 32'h0000_0888;  // Lines 3, 7 and 11

  typedef logic [N_IRQ-1:0] irq_t;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic              err;
  } mem_rsp_t;

  // What a single scratchpad bank sees
  typedef struct packed {
    logic              req;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [ROW_W-1:0]  row;
    logic [DATA_W-1:0] wdata;
  } bank_req_t;

endpackage
